/* conv_engine_params.svh */
`ifndef CONV_ENGINE_PARAMS_SVH
`define CONV_ENGINE_PARAMS_SVH

// sample and memory sizes
`define DATA_W        8
`define IF_ADDR_LEN   6
`define FILT_ADDR_LEN 4
`define SCRATCH_DEPTH 64
`define SCRATCH_WIDTH 24

`define APB_AW 12

// address map, memory word i at base + 4*i
`define CTRL_ADDR 12'h000
`define CFG_ADDR  12'h004
`define IF_BASE   12'h400
`define FILT_BASE 12'h800
`define RES_BASE  12'hC00

`endif

/* conv_cfg_pkg.sv */
package conv_cfg_pkg;

    `include "conv_engine_params.svh"

    typedef struct packed {
        logic [`APB_AW-1:0] paddr;
        logic               pwrite;
        logic [31:0]        pwdata;
        logic               psel;
        logic               penable;
    } apb_req_t;

    // one run, held constant while busy
    typedef struct packed {
        logic [6:0] if_len;
        logic [4:0] filt_len;
        logic [3:0] stride;
        logic       just_add;
    } run_cfg_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        just_add;
        logic        start;
    } ctrl_cmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        cfg_error;
        logic        done;
        logic        busy;
    } ctrl_stat_t;

    // CTRL_ADDR word, command on write and status on read
    typedef union packed {
        ctrl_cmd_t  cmd;
        ctrl_stat_t stat;
    } ctrl_word_u;

endpackage

/* conv_data_pkg.sv */
package conv_data_pkg;

    `include "conv_engine_params.svh"

    // host write into IF or filter memory
    typedef struct packed {
        logic                     en;
        logic                     sel_filt;   // 0 = IF, 1 = filter
        logic [`IF_ADDR_LEN-1:0]  addr;
        logic [`DATA_W-1:0]       data;
    } mem_wr_t;

    // one finished output toward the scratch buffer
    typedef struct packed {
        logic                               en;
        logic [$clog2(`SCRATCH_DEPTH)-1:0]  idx;
        logic signed [`SCRATCH_WIDTH-1:0]   value;
    } res_wr_t;

endpackage

/* apb_cfg_regs.sv */
`timescale 1ns/100ps
`include "conv_engine_params.svh"

module apb_cfg_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  conv_cfg_pkg::apb_req_t apb_req,
    output logic                   pready,
    output logic                   pslverr,
    output logic [31:0]            prdata,
    input  logic                   busy,
    input  logic                   done,
    output logic                   start,
    output conv_cfg_pkg::run_cfg_t cfg,
    output conv_data_pkg::mem_wr_t mem_wr,
    output logic [5:0]             res_rd_idx,
    input  logic signed [23:0]     res_rd_data
);
    import conv_cfg_pkg::*;

    localparam logic [`APB_AW-1:0] IF_MASK = ~`APB_AW'((1 << (`IF_ADDR_LEN + 2)) - 1);
    localparam logic [`APB_AW-1:0] FILT_MASK = ~`APB_AW'((1 << (`FILT_ADDR_LEN + 2)) - 1);
    localparam logic [`APB_AW-1:0] RES_MASK = ~`APB_AW'((1 << ($clog2(`SCRATCH_DEPTH) + 2)) - 1);

    logic       access;
    logic       wr_acc;
    logic       hit_ctrl;
    logic       hit_cfg;
    logic       hit_if;
    logic       hit_filt;
    logic       hit_res;
    logic       mapped;
    logic       cfg_ok;
    logic       cfg_error;
    ctrl_word_u cmd_w;
    ctrl_word_u stat_w;

    assign access = apb_req.psel & apb_req.penable;
    assign wr_acc = access & apb_req.pwrite;

    assign hit_ctrl = apb_req.paddr == `CTRL_ADDR;
    assign hit_cfg  = apb_req.paddr == `CFG_ADDR;
    assign hit_if   = (apb_req.paddr & IF_MASK) == `IF_BASE;
    assign hit_filt = (apb_req.paddr & FILT_MASK) == `FILT_BASE;
    assign hit_res  = (apb_req.paddr & RES_MASK) == `RES_BASE;
    assign mapped   = hit_ctrl | hit_cfg | hit_if | hit_filt | hit_res;

    assign pready  = 1'b1;   // no wait states
    assign pslverr = access & (~mapped | (apb_req.pwrite & hit_res));

    assign cmd_w = apb_req.pwdata;
    assign res_rd_idx = apb_req.paddr[7:2];

    // lengths must fit the local memories too
    assign cfg_ok = (cfg.filt_len != 5'd0) && ({2'b00, cfg.filt_len} <= cfg.if_len) &&
                    (cfg.stride != 4'd0) && (cfg.if_len <= 7'(1 << `IF_ADDR_LEN)) &&
                    (cfg.filt_len <= 5'(1 << `FILT_ADDR_LEN));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg       <= '0;
            start     <= 1'b0;
            cfg_error <= 1'b0;
            mem_wr    <= '0;
        end else begin
            start     <= 1'b0;
            mem_wr.en <= 1'b0;
            if (wr_acc && hit_ctrl && cmd_w.cmd.start && !busy) begin
                if (cfg_ok) begin
                    start        <= 1'b1;
                    cfg_error    <= 1'b0;
                    cfg.just_add <= cmd_w.cmd.just_add;
                end else begin
                    cfg_error <= 1'b1;   // sticky until next good start
                end
            end
            if (wr_acc && hit_cfg && !busy) begin
                cfg.if_len   <= apb_req.pwdata[6:0];
                cfg.filt_len <= apb_req.pwdata[12:8];
                cfg.stride   <= apb_req.pwdata[19:16];
            end
            if (wr_acc && (hit_if || hit_filt)) begin
                mem_wr.en       <= 1'b1;
                mem_wr.sel_filt <= hit_filt;
                mem_wr.addr     <= apb_req.paddr[7:2];
                mem_wr.data     <= apb_req.pwdata[`DATA_W-1:0];
            end
        end
    end

    always_comb begin
        stat_w                = '0;
        stat_w.stat.busy      = busy;
        stat_w.stat.done      = done;
        stat_w.stat.cfg_error = cfg_error;
        prdata                = '0;
        if (hit_ctrl)
            prdata = stat_w;
        else if (hit_cfg)
            prdata = {12'b0, cfg.stride, 3'b0, cfg.filt_len, 1'b0, cfg.if_len};
        else if (hit_res)
            prdata = 32'(res_rd_data);   // sign extended
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

/* design_controller.sv */
`timescale 1ns/100ps

module design_controller (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic full_done,
    input  logic psum_done,
    input  logic stride_count_flag,
    output logic reset_all,
    output logic IF_read_start,
    output logic filter_read_start,
    output logic clear_regs,
    output logic start_rd_gen,
    output logic busy,
    output logic done
);

    typedef enum logic [4:0] {
        IDLE   = 5'b00001,
        PRIME  = 5'b00010,
        RD_GEN = 5'b00100,
        MAC    = 5'b01000,
        DONE   = 5'b10000
    } state_t;

    state_t ps;
    state_t ns;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ps <= IDLE;
        else
            ps <= ns;
    end

    always_comb begin
        case (ps)
            IDLE:    ns = start ? PRIME : IDLE;
            PRIME:   ns = RD_GEN;
            RD_GEN:  ns = MAC;
            MAC: begin
                if (full_done)
                    ns = DONE;
                else if (psum_done)
                    ns = RD_GEN;   // next window
                else
                    ns = MAC;
            end
            DONE:    ns = start ? PRIME : DONE;
            default: ns = IDLE;
        endcase
    end

    assign reset_all         = ps == IDLE;
    assign IF_read_start     = ps == PRIME;
    assign filter_read_start = ps == PRIME;
    assign start_rd_gen      = ps == RD_GEN;
    assign clear_regs        = (ps == MAC) & (psum_done | stride_count_flag);
    assign busy              = (ps == PRIME) | (ps == RD_GEN) | (ps == MAC);
    assign done              = ps == DONE;

    a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(ps));

endmodule

/* conv_datapath.sv */
`timescale 1ns/100ps
`include "conv_engine_params.svh"

module conv_datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  conv_cfg_pkg::run_cfg_t cfg,
    input  conv_data_pkg::mem_wr_t mem_wr,
    input  logic                   reset_all,
    input  logic                   IF_read_start,
    input  logic                   filter_read_start,
    input  logic                   clear_regs,
    input  logic                   start_rd_gen,
    output logic                   psum_done,
    output logic                   stride_count_flag,
    output logic                   full_done,
    output conv_data_pkg::res_wr_t res_wr
);

    logic signed [`DATA_W-1:0]        if_mem [1 << `IF_ADDR_LEN];
    logic signed [`DATA_W-1:0]        filt_mem [1 << `FILT_ADDR_LEN];
    logic [6:0]                       base;     // k*stride
    logic [4:0]                       tap;
    logic [5:0]                       win;
    logic                             active;
    logic [6:0]                       if_addr;
    logic [7:0]                       next_end;
    logic                             last_win;
    logic signed [2*`DATA_W-1:0]      prod;
    logic signed [`SCRATCH_WIDTH-1:0] psum;
    logic signed [`SCRATCH_WIDTH-1:0] mac_sum;

    always_ff @(posedge clk) begin
        if (mem_wr.en && !mem_wr.sel_filt)
            if_mem[mem_wr.addr] <= mem_wr.data;
        if (mem_wr.en && mem_wr.sel_filt)
            filt_mem[mem_wr.addr[`FILT_ADDR_LEN-1:0]] <= mem_wr.data;
    end

    assign if_addr  = base + 7'(tap);
    assign next_end = {1'b0, base} + 8'(cfg.stride) + 8'(cfg.filt_len);
    assign last_win = next_end > {1'b0, cfg.if_len};   // no room for another window

    assign prod    = if_mem[if_addr[`IF_ADDR_LEN-1:0]] * filt_mem[tap[`FILT_ADDR_LEN-1:0]];
    assign mac_sum = psum + prod;

    assign psum_done         = active & (tap == cfg.filt_len - 5'd1);
    assign stride_count_flag = psum_done & ~last_win;
    assign full_done         = psum_done & last_win;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            tap    <= '0;
            win    <= '0;
            base   <= '0;
            psum   <= '0;
        end else if (reset_all) begin
            active <= 1'b0;
            tap    <= '0;
            win    <= '0;
            base   <= '0;
            psum   <= '0;
        end else begin
            if (IF_read_start) begin
                base <= '0;
                win  <= '0;
            end
            if (filter_read_start)
                tap <= '0;
            if (start_rd_gen) begin
                active <= 1'b1;
                tap    <= '0;
            end else if (active) begin
                if (psum_done)
                    active <= 1'b0;
                else
                    tap <= tap + 5'd1;
            end
            if (stride_count_flag) begin
                base <= base + 7'(cfg.stride);
                win  <= win + 6'd1;
            end
            if (clear_regs)
                psum <= '0;   // result already taken from mac_sum
            else if (active)
                psum <= mac_sum;
        end
    end

    // last tap result goes straight out, written on the same edge
    assign res_wr = '{en: psum_done, idx: win, value: mac_sum};

    a_if_addr_range: assert property (@(posedge clk) disable iff (rst)
        active |-> if_addr < cfg.if_len);

endmodule

/* result_buffer.sv */
`timescale 1ns/100ps
`include "conv_engine_params.svh"

module result_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  conv_data_pkg::res_wr_t           res_wr,
    input  logic                             just_add,
    input  logic [5:0]                       rd_idx,
    output logic signed [`SCRATCH_WIDTH-1:0] rd_data
);

    logic signed [`SCRATCH_WIDTH-1:0] scratch [`SCRATCH_DEPTH];
    logic signed [`SCRATCH_WIDTH-1:0] acc_sum;

    // old entry plus new output, for partial sums across channels
    assign acc_sum = scratch[res_wr.idx] + res_wr.value;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SCRATCH_DEPTH; i++)
                scratch[i] <= '0;
        end else if (res_wr.en) begin
            scratch[res_wr.idx] <= just_add ? acc_sum : res_wr.value;
        end
    end

    assign rd_data = scratch[rd_idx];   // host read, no latency

endmodule

/* conv_engine_top.sv */
`timescale 1ns/100ps

module conv_engine_top (
    input  logic                   clk,
    input  logic                   rst,
    input  conv_cfg_pkg::apb_req_t apb_req,
    output logic                   pready,
    output logic                   pslverr,
    output logic [31:0]            prdata
);
    import conv_cfg_pkg::*;
    import conv_data_pkg::*;

    run_cfg_t           cfg;
    mem_wr_t            mem_wr;
    res_wr_t            res_wr;
    logic               start;
    logic               busy;
    logic               done;
    logic               reset_all;
    logic               if_read_start;
    logic               filter_read_start;
    logic               clear_regs;
    logic               start_rd_gen;
    logic               psum_done;
    logic               stride_count_flag;
    logic               full_done;
    logic [5:0]         res_rd_idx;
    logic signed [23:0] res_rd_data;

    apb_cfg_regs apb_cfg_regs_i (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .pready      (pready),
        .pslverr     (pslverr),
        .prdata      (prdata),
        .busy        (busy),
        .done        (done),
        .start       (start),
        .cfg         (cfg),
        .mem_wr      (mem_wr),
        .res_rd_idx  (res_rd_idx),
        .res_rd_data (res_rd_data)
    );

    design_controller design_controller_i (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .full_done         (full_done),
        .psum_done         (psum_done),
        .stride_count_flag (stride_count_flag),
        .reset_all         (reset_all),
        .IF_read_start     (if_read_start),
        .filter_read_start (filter_read_start),
        .clear_regs        (clear_regs),
        .start_rd_gen      (start_rd_gen),
        .busy              (busy),
        .done              (done)
    );

    conv_datapath conv_datapath_i (
        .clk               (clk),
        .rst               (rst),
        .cfg               (cfg),
        .mem_wr            (mem_wr),
        .reset_all         (reset_all),
        .IF_read_start     (if_read_start),
        .filter_read_start (filter_read_start),
        .clear_regs        (clear_regs),
        .start_rd_gen      (start_rd_gen),
        .psum_done         (psum_done),
        .stride_count_flag (stride_count_flag),
        .full_done         (full_done),
        .res_wr            (res_wr)
    );

    result_buffer result_buffer_i (
        .clk      (clk),
        .rst      (rst),
        .res_wr   (res_wr),
        .just_add (cfg.just_add),
        .rd_idx   (res_rd_idx),
        .rd_data  (res_rd_data)
    );

endmodule

/* conv_engine_tb.sv */
`timescale 1ns/100ps
`include "conv_engine_params.svh"

module conv_engine_tb;
    import conv_cfg_pkg::*;

    // worst-case cycles per run plus slack for the status polling
    localparam int RUN_BOUNDS = 3 * (2 + 13 * 5 + 20) + 2 * (2 + 10 * 6 + 20);
    localparam int APB_OPS    = 6 * 64 + 4 * 37 + 40;   // result reads, memory loads, ctrl
    localparam int TIMEOUT    = RUN_BOUNDS + 3 * APB_OPS + 5 + 50;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;

    logic signed [7:0]  x_mem [64];
    logic signed [7:0]  f_mem [16];
    logic signed [23:0] exp_res [64];
    logic [31:0]        seed;
    int                 cycle;
    int                 test_errors;
    int                 total_errors;
    int                 tests_run;
    int                 tests_failed;

    conv_engine_top conv_engine_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    // setup on one falling edge, access on the next, idle on the third
    task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b1;
        apb_req.pwdata  = data;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1 err = pslverr;
        check_value({31'b0, pready}, 32'h1, "pready in write access phase");
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        data = prdata;   // valid in access phase
        err  = pslverr;
        check_value({31'b0, pready}, 32'h1, "pready in read access phase");
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic load_memories(input int if_len, input int filt_len);
        logic err;
        for (int i = 0; i < if_len; i++) begin
            seed     = lcg_step(seed);
            x_mem[i] = seed[23:16];
            apb_write(`IF_BASE + 12'(4 * i), {24'b0, seed[23:16]}, err);
        end
        for (int j = 0; j < filt_len; j++) begin
            seed     = lcg_step(seed);
            f_mem[j] = seed[23:16];
            apb_write(`FILT_BASE + 12'(4 * j), {24'b0, seed[23:16]}, err);
        end
    endtask

    task automatic configure_and_start(input int if_len, input int filt_len, input int stride,
                                       input logic just_add);
        logic err;
        apb_write(`CFG_ADDR, {12'b0, 4'(stride), 3'b0, 5'(filt_len), 1'b0, 7'(if_len)}, err);
        apb_write(`CTRL_ADDR, {30'b0, just_add, 1'b1}, err);
    endtask

    task automatic wait_for_done(input int bound);
        int          t0;
        logic [31:0] st;
        logic        err;
        t0 = cycle;
        st = '0;
        while (!st[1] && (cycle - t0) <= bound)
            apb_read(`CTRL_ADDR, st, err);
        assert (st[1]) else begin
            $display("run did not raise done within %0d cycles", bound);
            test_errors++;
        end
    endtask

    // y[k] = sum of f[j]*x[k*stride+j], kept in 24 bits
    task automatic update_model(input int if_len, input int filt_len, input int stride,
                                input logic just_add);
        int                 n_out;
        logic signed [23:0] acc;
        n_out = (if_len - filt_len) / stride + 1;
        for (int k = 0; k < n_out; k++) begin
            acc = '0;
            for (int j = 0; j < filt_len; j++)
                acc = acc + x_mem[k * stride + j] * f_mem[j];
            exp_res[k] = just_add ? exp_res[k] + acc : acc;
        end
    endtask

    task automatic run_conv(input int if_len, input int filt_len, input int stride,
                            input logic just_add);
        int n_out;
        n_out = (if_len - filt_len) / stride + 1;
        configure_and_start(if_len, filt_len, stride, just_add);
        wait_for_done(2 + n_out * (filt_len + 1) + 20);
        update_model(if_len, filt_len, stride, just_add);
    endtask

    task automatic check_results();
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < 64; i++) begin
            apb_read(`RES_BASE + 12'(4 * i), rd, err);
            check_value(rd, {{8{exp_res[i][23]}}, exp_res[i]}, $sformatf("result %0d", i));
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_reset_state();
        logic [31:0] st;
        logic        err;
        apb_read(`CTRL_ADDR, st, err);
        check_value(st, 32'h0, "status after reset");
        check_results();
        finish_test("reset_state");
    endtask

    task automatic test_stride_one();
        load_memories(16, 4);
        run_conv(16, 4, 1, 1'b0);
        check_results();
        finish_test("stride_one");
    endtask

    task automatic test_stride_three();
        load_memories(32, 5);
        run_conv(32, 5, 3, 1'b0);
        check_results();   // entries past 10 keep old values
        finish_test("stride_three");
    endtask

    task automatic test_just_add();
        load_memories(16, 4);
        run_conv(16, 4, 1, 1'b0);
        load_memories(16, 4);   // second channel
        run_conv(16, 4, 1, 1'b1);
        check_results();
        finish_test("just_add");
    endtask

    task automatic test_error_cases();
        logic [31:0] st;
        logic        err;
        configure_and_start(16, 20, 1, 1'b0);
        apb_read(`CTRL_ADDR, st, err);
        check_value(st & 32'h5, 32'h4, "status after filt_len > if_len");
        configure_and_start(16, 4, 0, 1'b0);
        apb_read(`CTRL_ADDR, st, err);
        check_value(st & 32'h5, 32'h4, "status after stride 0");
        apb_read(12'h100, st, err);
        check_value({31'b0, err}, 32'h1, "pslverr on unmapped read");
        apb_write(`RES_BASE + 12'h8, 32'h1234, err);
        check_value({31'b0, err}, 32'h1, "pslverr on result write");
        check_results();
        finish_test("error_cases");
    endtask

    task automatic test_start_while_busy();
        logic [31:0] st;
        logic        err;
        load_memories(32, 5);
        configure_and_start(32, 5, 3, 1'b0);
        configure_and_start(16, 4, 1, 1'b1);   // lands mid-run
        wait_for_done(2 + 10 * 6 + 20);
        update_model(32, 5, 3, 1'b0);
        apb_read(`CTRL_ADDR, st, err);
        check_value(st, 32'h2, "status after run");
        check_results();
        finish_test("start_while_busy");
    endtask

    initial begin
        rst          = 1'b1;
        apb_req      = '0;
        seed         = 32'heed5;
        cycle        = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 64; i++)
            exp_res[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_stride_one();
        test_stride_three();
        test_just_add();
        test_error_cases();
        test_start_while_busy();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* conv_engine.f */
+incdir+.
conv_cfg_pkg.sv
conv_data_pkg.sv
apb_cfg_regs.sv
design_controller.sv
conv_datapath.sv
result_buffer.sv
conv_engine_top.sv
conv_engine_tb.sv

/* Makefile */
SIM = obj_dir/conv_engine_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f conv_engine.f \
		--top-module conv_engine_tb -o conv_engine_sim

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
